// File: Bender.yml
package:
  name: ifu_ifetch

sources:
  - hdl/ifu_pkg.sv
  - hdl/ifu_pc_sel_if.sv
  - hdl/ifu_fetch_ctrl.sv
  - hdl/ifu_branch_predict.sv
  - hdl/ifu_pc_gen.sv
  - hdl/ifu_ir_stage.sv
  - hdl/ifu_ifetch.sv
  - target: test
    files:
      - tb/ifu_ifetch_tb.sv

// File: flist.f
hdl/ifu_pkg.sv
hdl/ifu_pc_sel_if.sv
hdl/ifu_fetch_ctrl.sv
hdl/ifu_branch_predict.sv
hdl/ifu_pc_gen.sv
hdl/ifu_ir_stage.sv
hdl/ifu_ifetch.sv
tb/ifu_ifetch_tb.sv

// File: hdl/ifu_branch_predict.sv
/*
  Static predictor on the returning fetch word. JAL always taken, conditional branch
  taken only when backward. JALR is not predicted and falls through.
*/
`timescale 1ns/1ps

module ifu_branch_predict (
  input  ifu_pkg::instr_t rsp_instr,
  input  logic            rsp_valid,
  input  ifu_pkg::pc_t    pc_r,
  output logic            prdt_taken,
  ifu_pc_sel_if.bpu       sel
);
  import ifu_pkg::*;

  logic dec_jal;
  logic dec_bxx;
  pc_t  imm_j;
  pc_t  imm_b;

  ////////////////////
  // Mini-decode
  ////////////////////
  assign dec_jal = (rsp_instr[6:0] == OPC_JAL);
  assign dec_bxx = (rsp_instr[6:0] == OPC_BRANCH);

  // J immediate, sign bit in instr[31]
  assign imm_j = {{(PC_W-20){rsp_instr[31]}},
                  rsp_instr[19:12],
                  rsp_instr[20],
                  rsp_instr[30:21],
                  1'b0};

  // B immediate
  assign imm_b = {{(PC_W-12){rsp_instr[31]}},
                  rsp_instr[7],
                  rsp_instr[30:25],
                  rsp_instr[11:8],
                  1'b0};

  ////////////////////
  // Taken rule
  ////////////////////
  // Negative offset means a loop back edge
  assign prdt_taken = dec_jal | (dec_bxx & imm_b[PC_W-1]);

  // Only redirect on a real returning word
  assign sel.bjp_req  = prdt_taken & rsp_valid;
  // Target is the PC of this word plus its offset
  assign sel.prdt_op1 = pc_r;
  assign sel.prdt_op2 = dec_jal ? imm_j : imm_b;

endmodule

// File: hdl/ifu_fetch_ctrl.sv
/*
  Fetch control flags. Only one fetch may be outstanding at a time.
  A flush is always taken; if the request bus is busy it waits as a delayed flush.
*/
`timescale 1ns/1ps

module ifu_fetch_ctrl (
  input  logic       clk,
  input  logic       rst,
  output logic       req_valid,
  input  logic       req_ready,
  input  logic       rsp_valid,
  output logic       rsp_ready,
  input  logic       flush_req,
  input  logic       halt_req,
  output logic       halt_ack,
  input  logic       ir_ready,
  output logic       ir_load,
  ifu_pc_sel_if.ctrl sel
);

  logic req_hsk;
  logic rsp_hsk;
  logic reset_flag_r;
  logic reset_req_r;
  logic out_flag_r;
  logic out_flag_nxt;
  logic dly_flush_r;
  logic flush_real;
  logic new_req;
  logic new_req_condi;

  assign req_hsk = req_valid & req_ready;
  assign rsp_hsk = rsp_valid & rsp_ready;

  ////////////////////
  // Reset request
  ////////////////////
  // High during reset and for one cycle after
  always_ff @(posedge clk) begin
    reset_flag_r <= rst;
  end

  // Raised once after reset, dropped when the reset vector is requested
  always_ff @(posedge clk) begin
    if (rst) begin
      reset_req_r <= 1'b0;
    end else if (reset_flag_r & ~reset_req_r) begin
      reset_req_r <= 1'b1;
    end else if (reset_req_r & req_hsk) begin
      reset_req_r <= 1'b0;
    end
  end

  ////////////////////
  // Outstanding fetch
  ////////////////////
  // Set wins over clear when a new request goes out as the old one returns
  assign out_flag_nxt = req_hsk | (out_flag_r & ~rsp_hsk);

  always_ff @(posedge clk) begin
    if (rst) out_flag_r <= 1'b0;
    else     out_flag_r <= out_flag_nxt;
  end

  ////////////////////
  // Delayed flush
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      dly_flush_r <= 1'b0;
    end else if (flush_req & ~req_hsk) begin
      dly_flush_r <= 1'b1;
    end else if (dly_flush_r & req_hsk) begin
      dly_flush_r <= 1'b0;
    end
  end

  assign flush_real = flush_req | dly_flush_r;

  ////////////////////
  // Halt acknowledge
  ////////////////////
  // Only once nothing is left in flight after this cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      halt_ack <= 1'b0;
    end else if (halt_req & ~halt_ack & ~out_flag_nxt) begin
      halt_ack <= 1'b1;
    end else if (halt_ack & ~halt_req) begin
      halt_ack <= 1'b0;
    end
  end

  ////////////////////
  // Request and response
  ////////////////////
  // No sequential fetch while halted or in the cycle right after reset
  assign new_req       = ~halt_req & ~reset_flag_r;
  // Bus free, or the outstanding fetch ends in this cycle
  assign new_req_condi = ~out_flag_r | rsp_hsk;
  assign req_valid     = (new_req | reset_req_r | flush_real) & new_req_condi;

  // Under flush the word is dropped, else it needs room in the IR and a free request bus
  assign rsp_ready = flush_real ? 1'b1 : (ir_ready & req_ready);
  assign ir_load   = rsp_hsk & ~flush_real;

  assign sel.reset_req = reset_req_r;
  assign sel.dly_flush = dly_flush_r;
  // PC moves on a request or when execute redirects
  assign sel.pc_ena    = req_hsk | flush_req;

  a_req_valid_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(req_valid));

  // Once acknowledged, halt keeps the request bus quiet unless execute redirects
  a_halt_no_req: assert property (@(posedge clk) disable iff (rst)
    halt_ack && halt_req && !flush_real |-> !req_valid);

endmodule

// File: hdl/ifu_ifetch.sv
/*
  Fetch stage top. One outstanding fetch, flush_ack tied high.
  The flush target is flush_op1 + flush_op2 with bit 0 cleared.
*/
`timescale 1ns/1ps

module ifu_ifetch (
  input  logic            clk,
  input  logic            rst,
  input  ifu_pkg::pc_t    pc_rtvec,
  // Fetch request
  output logic            req_valid,
  input  logic            req_ready,
  output ifu_pkg::pc_t    req_pc,
  // Fetch response
  input  logic            rsp_valid,
  output logic            rsp_ready,
  input  logic            rsp_err,
  input  ifu_pkg::instr_t rsp_instr,
  // Toward execute
  output ifu_pkg::instr_t o_ir,
  output ifu_pkg::pc_t    o_pc,
  output logic            o_pc_vld,
  output logic            o_prdt_taken,
  output logic            o_buserr,
  output logic            o_valid,
  input  logic            o_ready,
  // Flush from execute
  input  logic            flush_req,
  output logic            flush_ack,
  input  ifu_pkg::pc_t    flush_op1,
  input  ifu_pkg::pc_t    flush_op2,
  // Halt
  input  logic            halt_req,
  output logic            halt_ack
);
  import ifu_pkg::*;

  logic    ir_ready;
  logic    ir_load;
  logic    prdt_taken;
  pc_t     pc_r;
  ir_out_t ir_out;

  ifu_pc_sel_if sel_if ();

  // Never stall execute on a flush
  assign flush_ack = 1'b1;

  ifu_fetch_ctrl u_fetch_ctrl (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .flush_req (flush_req),
    .halt_req  (halt_req),
    .halt_ack  (halt_ack),
    .ir_ready  (ir_ready),
    .ir_load   (ir_load),
    .sel       (sel_if.ctrl)
  );

  ifu_branch_predict u_branch_predict (
    .rsp_instr  (rsp_instr),
    .rsp_valid  (rsp_valid),
    .pc_r       (pc_r),
    .prdt_taken (prdt_taken),
    .sel        (sel_if.bpu)
  );

  ifu_pc_gen u_pc_gen (
    .clk       (clk),
    .rst       (rst),
    .pc_rtvec  (pc_rtvec),
    .flush_req (flush_req),
    .flush_op1 (flush_op1),
    .flush_op2 (flush_op2),
    .sel       (sel_if.pc),
    .pc_r      (pc_r),
    .req_pc    (req_pc)
  );

  ifu_ir_stage u_ir_stage (
    .clk        (clk),
    .rst        (rst),
    .ir_load    (ir_load),
    .rsp_instr  (rsp_instr),
    .rsp_err    (rsp_err),
    .prdt_taken (prdt_taken),
    .pc_r       (pc_r),
    .pc_ena     (sel_if.pc_ena),
    .flush_req  (flush_req),
    .o_ready    (o_ready),
    .ir_ready   (ir_ready),
    .o_valid    (o_valid),
    .o_pc_vld   (o_pc_vld),
    .ir_out     (ir_out)
  );

  // Split the IR result into plain ports
  assign o_ir         = ir_out.ir;
  assign o_pc         = ir_out.pc;
  assign o_buserr     = ir_out.buserr;
  assign o_prdt_taken = ir_out.prdt_taken;

endmodule

// File: hdl/ifu_ir_stage.sv
/*
  Instruction register toward execute. Holds one word; fields stay put while stalled.
  The PC field is loaded together with the word it belongs to.
*/
`timescale 1ns/1ps

module ifu_ir_stage (
  input  logic             clk,
  input  logic             rst,
  input  logic             ir_load,
  input  ifu_pkg::instr_t  rsp_instr,
  input  logic             rsp_err,
  input  logic             prdt_taken,
  input  ifu_pkg::pc_t     pc_r,
  input  logic             pc_ena,
  input  logic             flush_req,
  input  logic             o_ready,
  output logic             ir_ready,
  output logic             o_valid,
  output logic             o_pc_vld,
  output ifu_pkg::ir_out_t ir_out
);

  logic valid_clr;
  logic pc_vld_set;
  logic pc_newpend_r;

  // Taken by execute, or killed by a flush while full
  assign valid_clr  = (o_valid & o_ready) | (flush_req & o_valid);
  // Empty or emptying in this cycle
  assign ir_ready   = ~o_valid | valid_clr;
  assign pc_vld_set = pc_newpend_r & ir_load;

  ////////////////////
  // Control flags
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid  <= 1'b0;
      o_pc_vld <= 1'b0;
    end else begin
      if (ir_load)        o_valid <= 1'b1;
      else if (valid_clr) o_valid <= 1'b0;
      if (pc_vld_set)     o_pc_vld <= 1'b1;
      else if (valid_clr) o_pc_vld <= 1'b0;
    end
  end

  // A PC was loaded that the IR has not picked up yet
  always_ff @(posedge clk) begin
    if (rst)             pc_newpend_r <= 1'b0;
    else if (pc_ena)     pc_newpend_r <= 1'b1;
    else if (pc_vld_set) pc_newpend_r <= 1'b0;
  end

  ////////////////////
  // Payload
  ////////////////////
  always_ff @(posedge clk) begin
    if (ir_load) begin
      ir_out.ir         <= rsp_instr;
      ir_out.buserr     <= rsp_err;
      ir_out.prdt_taken <= prdt_taken;
    end
    if (pc_vld_set) ir_out.pc <= pc_r;
  end

  a_ir_stall_stable: assert property (@(posedge clk) disable iff (rst)
    o_valid && !o_ready && !flush_req |=> o_valid && $stable(ir_out));

endmodule

// File: hdl/ifu_pc_gen.sv
/*
  PC register and next-PC adder. Bit 0 of the result is always cleared.
*/
`timescale 1ns/1ps

module ifu_pc_gen (
  input  logic         clk,
  input  logic         rst,
  input  ifu_pkg::pc_t pc_rtvec,
  input  logic         flush_req,
  input  ifu_pkg::pc_t flush_op1,
  input  ifu_pkg::pc_t flush_op2,
  ifu_pc_sel_if.pc     sel,
  output ifu_pkg::pc_t pc_r,
  output ifu_pkg::pc_t req_pc
);
  import ifu_pkg::*;

  pc_t add_op1;
  pc_t add_op2;
  pc_t pc_sum;

  ////////////////////
  // Operand select
  ////////////////////
  always_comb begin
    if (flush_req) begin
      add_op1 = flush_op1;
      add_op2 = flush_op2;
    end else if (sel.dly_flush) begin
      // pc_r already holds the flush target
      add_op1 = pc_r;
      add_op2 = '0;
    end else if (sel.bjp_req) begin
      add_op1 = sel.prdt_op1;
      add_op2 = sel.prdt_op2;
    end else if (sel.reset_req) begin
      add_op1 = pc_rtvec;
      add_op2 = '0;
    end else begin
      add_op1 = pc_r;
      add_op2 = FETCH_INCR;
    end
  end

  // One shared adder for every source
  assign pc_sum = add_op1 + add_op2;
  assign req_pc = {pc_sum[PC_W-1:1], 1'b0};

  always_ff @(posedge clk) begin
    if (rst)             pc_r <= '0;
    else if (sel.pc_ena) pc_r <= req_pc;
  end

endmodule

// File: hdl/ifu_pc_sel_if.sv
/*
  Next-PC select lines. Control and predictor drive, the PC generator only reads.
*/
`timescale 1ns/1ps

interface ifu_pc_sel_if;
  import ifu_pkg::*;

  // From fetch control
  logic reset_req;
  logic dly_flush;
  logic pc_ena;

  // From the static predictor
  logic bjp_req;
  pc_t  prdt_op1;
  pc_t  prdt_op2;

  modport ctrl (output reset_req, dly_flush, pc_ena);
  modport bpu  (output bjp_req, prdt_op1, prdt_op2);
  modport pc   (input reset_req, dly_flush, pc_ena, bjp_req, prdt_op1, prdt_op2);

endinterface

// File: hdl/ifu_pkg.sv
/*
  Shared types and constants for the fetch stage. RV32 only, aligned 32-bit words,
  no compressed instructions, so the sequential step is always 4 bytes.
*/
package ifu_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int PC_W    = 32;
  localparam int INSTR_W = 32;

  typedef logic [PC_W-1:0]    pc_t;
  typedef logic [INSTR_W-1:0] instr_t;

  // Sequential fetch step in bytes
  localparam pc_t FETCH_INCR = 32'd4;

  ////////////////////
  // Major opcodes
  ////////////////////
  // Unconditional jump with a J immediate
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  // BEQ, BNE, BLT, BGE, BLTU, BGEU
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  ////////////////////
  // IR stage result
  ////////////////////
  // What execute sees for one fetched instruction
  typedef struct packed {
    // Raw instruction word
    instr_t ir;
    // Address it was fetched from
    pc_t    pc;
    // Fetch bus returned an error for this word
    logic   buserr;
    // Static predictor redirected fetch after this word
    logic   prdt_taken;
  } ir_out_t;

endpackage

// File: tb/ifu_ifetch_tb.sv
/*
  Testbench for the fetch stage. Records come from tb/ifu_input.txt; req_ready stays high.
  Unlisted addresses return a non-branch fill word built from the whole address.
*/
`timescale 1ns/1ps

module ifu_ifetch_tb;
  import ifu_pkg::*;

  logic clk, rst, req_valid, req_ready, rsp_valid, rsp_ready, rsp_err;
  pc_t pc_rtvec, req_pc, o_pc, flush_op1, flush_op2;
  instr_t rsp_instr, o_ir;
  logic o_pc_vld, o_prdt_taken, o_buserr, o_valid, o_ready;
  logic flush_req, flush_ack, halt_req, halt_ack;

  // Current test record
  string test_name;
  pc_t test_rtvec;
  ir_out_t exp_q[$];
  byte ev_kind;
  int ev_after;
  pc_t ev_op1, ev_op2;
  instr_t mem_word_a[pc_t];
  logic mem_err_a[pc_t];

  // Memory model and execute state
  logic mem_pend, rv_chk, flush_chk, halt_seen;
  pc_t mem_addr;
  ir_out_t got_ir;
  int mem_wait, n_got, halt_cnt, test_errs, err_total, n_tests, n_failed;
  int unsigned lcg_state = 13;

  ifu_ifetch ifu_ifetch_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // Fill keeps opcode OP-IMM so it never predicts
  function automatic instr_t word_at(pc_t a);
    if (mem_word_a.exists(a)) return mem_word_a[a];
    return {a[31:7] ^ a[24:0], 7'h13};
  endfunction

  function automatic logic err_at(pc_t a);
    if (mem_err_a.exists(a)) return mem_err_a[a];
    return 1'b0;
  endfunction

  task automatic compare_ir(input ir_out_t exp, input ir_out_t act);
    if (act !== exp) begin
      $display("** Error %s: exp pc=%h ir=%h tk=%b be=%b, act pc=%h ir=%h tk=%b be=%b",
               test_name, exp.pc, exp.ir, exp.prdt_taken, exp.buserr,
               act.pc, act.ir, act.prdt_taken, act.buserr);
      test_errs++;
    end
  endtask

  task automatic compare_pc(input string what, input pc_t exp, input pc_t act);
    if (act !== exp) begin
      $display("** Error %s: %s req_pc expected %h, actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic compare_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: %s expected %b, actual %b", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  ////////////////////
  // Memory and execute model
  ////////////////////
  always @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
      o_ready   <= 1'b0;
      flush_req <= 1'b0;
      halt_req  <= 1'b0;
      mem_pend  = 1'b0;
    end else begin
      if (rsp_valid && rsp_ready) rsp_valid <= 1'b0;
      if (req_valid && req_ready) begin
        if (rv_chk) compare_pc("reset vector", test_rtvec, req_pc);
        if (flush_chk) compare_pc("flush target", (ev_op1 + ev_op2) & ~32'd1, req_pc);
        rv_chk    = 1'b0;
        flush_chk = 1'b0;
        mem_pend  = 1'b1;
        mem_addr  = req_pc;
        mem_wait  = lcg_next() % 4;
      end else if (mem_pend) begin
        if (mem_wait == 0) begin
          rsp_valid <= 1'b1;
          rsp_instr <= word_at(mem_addr);
          rsp_err   <= err_at(mem_addr);
          mem_pend  = 1'b0;
        end else begin
          mem_wait--;
        end
      end
      // Halt window
      if (halt_req && halt_ack && req_valid) begin
        $display("** %s: fetch request issued while halt_ack was high", test_name);
        test_errs++;
      end
      if (halt_req && halt_ack) begin
        halt_seen = 1'b1;
        halt_cnt++;
        if (halt_cnt == 4) halt_req <= 1'b0;
      end
      // Flush is never refused
      if (flush_req) compare_flag("flush_ack", 1'b1, flush_ack);
      // Execute side, o_ready low about one cycle in four
      o_ready   <= (lcg_next() % 4) != 0;
      flush_req <= 1'b0;
      if (o_valid && o_ready && n_got < exp_q.size()) begin
        got_ir.ir         = o_ir;
        got_ir.pc         = o_pc;
        got_ir.buserr     = o_buserr;
        got_ir.prdt_taken = o_prdt_taken;
        compare_ir(exp_q[n_got], got_ir);
        // Every delivered word came from a requested PC
        compare_flag("o_pc_vld", 1'b1, o_pc_vld);
        n_got++;
        if (n_got == ev_after && ev_kind == "f") begin
          flush_req <= 1'b1;
          flush_op1 <= ev_op1;
          flush_op2 <= ev_op2;
          o_ready   <= 1'b0;
          flush_chk = 1'b1;
        end else if (n_got == ev_after && ev_kind == "h") begin
          halt_req <= 1'b1;
        end
      end
    end
  end

  task automatic run_test();
    int cyc;
    int limit;
    cyc   = 0;
    limit = 40 * exp_q.size() + 60;
    n_got = 0;
    test_errs = 0;
    halt_cnt  = 0;
    halt_seen = 1'b0;
    flush_chk = 1'b0;
    rv_chk    = 1'b1;
    @(posedge clk);
    rst      <= 1'b1;
    pc_rtvec <= test_rtvec;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    while (n_got < exp_q.size() && cyc < limit) begin
      @(negedge clk);
      cyc++;
    end
    if (n_got < exp_q.size()) begin
      $display("test %s: timed out with %0d of %0d instructions delivered",
               test_name, n_got, exp_q.size());
      $display("=== FAIL ===");
      $finish;
    end else begin
      if (ev_kind == "h" && !halt_seen) begin
        $display("** %s: halt_ack never rose", test_name);
        test_errs++;
      end
      $display("test %s: %0d instructions, %0d errors", test_name, n_got, test_errs);
      n_tests++;
      err_total += test_errs;
      if (test_errs != 0) n_failed++;
      @(posedge clk);
      rst <= 1'b1;
      @(negedge clk);
    end
  endtask

  ////////////////////
  // Record parser
  ////////////////////
  initial begin
    int fd;
    int r;
    bit have_test;
    string line;
    byte key;
    logic [31:0] a, w, e;
    ir_out_t exp_item;
    rst = 1'b1;
    pc_rtvec = '0;
    req_ready = 1'b1;
    rsp_valid = 1'b0;
    rsp_err = 1'b0;
    rsp_instr = '0;
    o_ready = 1'b0;
    flush_req = 1'b0;
    flush_op1 = '0;
    flush_op2 = '0;
    halt_req = 1'b0;
    have_test = 1'b0;
    fd = $fopen("tb/ifu_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/ifu_input.txt");
      $display("=== FAIL ===");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        r = $fgets(line, fd);
        key = (line.len() > 0) ? line[0] : "#";
        if (key == "t") begin
          if (have_test) run_test();
          have_test = 1'b1;
          exp_q.delete();
          mem_word_a.delete();
          mem_err_a.delete();
          ev_kind = 0;
          ev_after = -1;
          r = $sscanf(line, "t %s %h", test_name, test_rtvec);
        end else if (key == "m") begin
          r = $sscanf(line, "m %h %h %h", a, w, e);
          mem_word_a[a] = w;
          mem_err_a[a]  = e[0];
        end else if (key == "f" || key == "h") begin
          ev_kind = key;
          r = $sscanf(line, "%c %d %h %h", key, ev_after, ev_op1, ev_op2);
        end else if (key == "x") begin
          r = $sscanf(line, "x %h %h %h", a, w, e);
          exp_item.ir         = word_at(a);
          exp_item.pc         = a;
          exp_item.buserr     = e[0];
          exp_item.prdt_taken = w[0];
          exp_q.push_back(exp_item);
        end
      end
      $fclose(fd);
      if (have_test) run_test();
      $display("totals: %0d tests, %0d failed, %0d errors", n_tests, n_failed, err_total);
      if (err_total == 0 && n_tests > 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

endmodule

// File: tb/ifu_input.txt
# t name reset_vector | m addr word err | f after_n op1 op2 | h after_n
# x pc taken buserr  (expected delivery, ir is the memory word at pc)
t seq 200
x 200 0 0
x 204 0 0
x 208 0 0
x 20c 0 0
t branch 300
m 304 0080006f 0
m 310 00000463 0
m 318 fe000ce3 0
x 300 0 0
x 304 1 0
x 30c 0 0
x 310 0 0
x 314 0 0
x 318 1 0
x 310 0 0
t flush 400
f 2 500 9
x 400 0 0
x 404 0 0
x 508 0 0
x 50c 0 0
t halt 600
h 2
x 600 0 0
x 604 0 0
x 608 0 0
x 60c 0 0
x 610 0 0
t buserr 700
m 704 00000013 1
x 700 0 0
x 704 0 1
x 708 0 0
